// ==== verilog/vid_regs_defines.svh ====
// video register front end
// shared widths, configuration length and register reset values

`ifndef VID_REGS_DEFINES_SVH
`define VID_REGS_DEFINES_SVH

// data word width of both register banks
`define VR_WORD_W 16

// register word address within a bank
`define VR_ADDR_W 5

// length of the board configuration stream in bytes
`define VR_CFG_BYTES 21

// priority words come up with every layer masked
`define VR_PRIO_RESET 16'hffff

// all six palette pages copied after reset
`define VR_PAL_PAGE_RESET 6'h3f

`endif

// ==== verilog/vid_regs_pkg.sv ====
// video register front end
// common vector types and the bridge state encoding

`include "vid_regs_defines.svh"

package vid_regs_pkg;

    // one register or data word
    typedef logic [`VR_WORD_W-1:0] word_t;

    // word address inside a bank
    typedef logic [`VR_ADDR_W-1:0] reg_addr_t;

    // one byte of the configuration stream
    typedef logic [7:0] cfg_byte_t;

    // byte lanes, active low, bit 1 is the upper byte
    typedef logic [1:0] lane_t;

    // host bridge FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        RESPOND = 2'd2
    } bridge_state_t;

endpackage

// ==== verilog/vid_bus_if.sv ====
// video register front end
// internal chip-select bus from the host bridge to the two register banks

`timescale 1ns/1ps

interface vid_bus_if;

    // one-cycle chip selects, never both high
    logic                      sel_fixed;
    logic                      sel_board;
    vid_regs_pkg::reg_addr_t   addr;
    vid_regs_pkg::lane_t       lanes;
    vid_regs_pkg::word_t       wdata;
    logic                      write;
    // registered read data from the board bank
    vid_regs_pkg::word_t       rdata;

    modport bridge (
        output sel_fixed, sel_board, addr, lanes, wdata, write,
        input  rdata
    );

    modport fixed_bank (
        input sel_fixed, addr, lanes, wdata, write
    );

    modport board_bank (
        input  sel_board, addr, lanes, wdata, write,
        output rdata
    );

endinterface

// ==== verilog/host_bus_bridge.sv ====
// host bus bridge
// accepts one valid/ready request at a time, runs a single chip-select
// cycle on the internal bus and returns the response under back-pressure

`timescale 1ns/1ps

module host_bus_bridge (
    input  logic                    clk,
    input  logic                    reg_rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_write,
    input  logic                    req_bank,
    input  vid_regs_pkg::reg_addr_t req_addr,
    input  logic [1:0]              req_be,
    input  vid_regs_pkg::word_t     req_wdata,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output vid_regs_pkg::word_t     rsp_rdata,
    vid_bus_if.bridge               bus
);

    vid_regs_pkg::bridge_state_t state;
    logic bank_q;
    logic write_q;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            state   <= vid_regs_pkg::IDLE;
            bank_q  <= 1'b0;
            write_q <= 1'b0;
        end else begin
            case (state)
                vid_regs_pkg::IDLE: begin
                    if (req_valid) begin
                        bank_q  <= req_bank;
                        write_q <= req_write;
                        state   <= vid_regs_pkg::ACCESS;
                    end
                end
                vid_regs_pkg::ACCESS:
                    state <= vid_regs_pkg::RESPOND;
                vid_regs_pkg::RESPOND: begin
                    if (rsp_ready)
                        state <= vid_regs_pkg::IDLE;
                end
                default:
                    state <= vid_regs_pkg::IDLE;
            endcase
        end
    end

    // request payload, only sampled on acceptance
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            bus.addr  <= req_addr;
            bus.lanes <= ~req_be;
            bus.wdata <= req_wdata;
        end
    end

    assign req_ready     = (state == vid_regs_pkg::IDLE);
    assign rsp_valid     = (state == vid_regs_pkg::RESPOND);
    assign bus.write     = write_q;
    assign bus.sel_fixed = (state == vid_regs_pkg::ACCESS) && !bank_q;
    assign bus.sel_board = (state == vid_regs_pkg::ACCESS) && bank_q;

    // board read register only changes on the next select, so it holds
    // for the whole response; fixed reads and writes return all ones
    assign rsp_rdata = (bank_q && !write_q) ? bus.rdata : '1;

    a_one_select: assert property (@(posedge clk) disable iff (reg_rst)
        !(bus.sel_fixed && bus.sel_board));

    a_rsp_hold: assert property (@(posedge clk) disable iff (reg_rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

// ==== verilog/fixed_reg_bank.sv ====
// fixed-address register bank
// scroll, star field, VRAM bases, palette base and video control,
// byte-lane writes and the palette copy pulse

`timescale 1ns/1ps

module fixed_reg_bank (
    input  logic                clk,
    input  logic                reg_rst,
    vid_bus_if.fixed_bank       bus,
    output vid_regs_pkg::word_t ppu_ctrl,
    output vid_regs_pkg::word_t hpos1,
    output vid_regs_pkg::word_t hpos2,
    output vid_regs_pkg::word_t hpos3,
    output vid_regs_pkg::word_t vpos1,
    output vid_regs_pkg::word_t vpos2,
    output vid_regs_pkg::word_t vpos3,
    output vid_regs_pkg::word_t hstar1,
    output vid_regs_pkg::word_t hstar2,
    output vid_regs_pkg::word_t vstar1,
    output vid_regs_pkg::word_t vstar2,
    output vid_regs_pkg::word_t vram1_base,
    output vid_regs_pkg::word_t vram2_base,
    output vid_regs_pkg::word_t vram3_base,
    output vid_regs_pkg::word_t vram_obj_base,
    output vid_regs_pkg::word_t vram_row_base,
    output vid_regs_pkg::word_t vram_star_base,
    output vid_regs_pkg::word_t pal_base,
    output logic                pal_copy
);

    // word addresses 0x00 to 0x11
    localparam int N_REGS  = 18;
    localparam int PAL_IDX = 5;

    vid_regs_pkg::word_t regs_q [N_REGS];
    logic pre_copy;

    // keep the old byte where the lane is disabled
    function automatic vid_regs_pkg::word_t lane_merge(
        input vid_regs_pkg::word_t old_w,
        input vid_regs_pkg::word_t new_w,
        input vid_regs_pkg::lane_t lanes
    );
        lane_merge[15:8] = lanes[1] ? old_w[15:8] : new_w[15:8];
        lane_merge[7:0]  = lanes[0] ? old_w[7:0]  : new_w[7:0];
    endfunction

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            for (int i = 0; i < N_REGS; i++)
                regs_q[i] <= '0;
            pre_copy <= 1'b0;
            pal_copy <= 1'b0;
        end else begin
            // copy waits until the select has dropped so pal_base is settled
            pal_copy <= pre_copy && !bus.sel_fixed;
            if (pre_copy && !bus.sel_fixed)
                pre_copy <= 1'b0;
            if (bus.sel_fixed && bus.write && bus.addr < N_REGS) begin
                regs_q[bus.addr] <= lane_merge(regs_q[bus.addr], bus.wdata, bus.lanes);
                if (bus.addr == PAL_IDX)
                    pre_copy <= 1'b1;
            end
        end
    end

    // chip register order
    assign vram_obj_base  = regs_q[0];
    assign vram1_base     = regs_q[1];
    assign vram2_base     = regs_q[2];
    assign vram3_base     = regs_q[3];
    assign vram_row_base  = regs_q[4];
    assign pal_base       = regs_q[PAL_IDX];
    assign hpos1          = regs_q[6];
    assign vpos1          = regs_q[7];
    assign hpos2          = regs_q[8];
    assign vpos2          = regs_q[9];
    assign hpos3          = regs_q[10];
    assign vpos3          = regs_q[11];
    assign hstar1         = regs_q[12];
    assign vstar1         = regs_q[13];
    assign hstar2         = regs_q[14];
    assign vstar2         = regs_q[15];
    assign vram_star_base = regs_q[16];
    assign ppu_ctrl       = regs_q[17];

    a_copy_single: assert property (@(posedge clk) disable iff (reg_rst)
        pal_copy |=> !pal_copy);

endmodule

// ==== verilog/board_config.sv ====
// board configuration
// byte-wide shift register loaded at start-up, decoded into the board
// register address map, layer masks, game code and ROM bank fields

`timescale 1ns/1ps
`include "vid_regs_defines.svh"

module board_config (
    input  logic                      clk,
    input  logic                      cfg_we,
    input  vid_regs_pkg::cfg_byte_t   cfg_data,
    output vid_regs_pkg::reg_addr_t   addr_id,
    output vid_regs_pkg::reg_addr_t   addr_mult1,
    output vid_regs_pkg::reg_addr_t   addr_mult2,
    output vid_regs_pkg::reg_addr_t   addr_rslt0,
    output vid_regs_pkg::reg_addr_t   addr_rslt1,
    output vid_regs_pkg::reg_addr_t   addr_layer,
    output vid_regs_pkg::reg_addr_t   addr_prio0,
    output vid_regs_pkg::reg_addr_t   addr_prio1,
    output vid_regs_pkg::reg_addr_t   addr_prio2,
    output vid_regs_pkg::reg_addr_t   addr_prio3,
    output vid_regs_pkg::reg_addr_t   addr_pal_page,
    output vid_regs_pkg::cfg_byte_t   board_id,
    output vid_regs_pkg::cfg_byte_t   layer_mask0,
    output vid_regs_pkg::cfg_byte_t   layer_mask1,
    output vid_regs_pkg::cfg_byte_t   layer_mask2,
    output vid_regs_pkg::cfg_byte_t   layer_mask3,
    output vid_regs_pkg::cfg_byte_t   layer_mask4,
    output logic [5:0]                game,
    output vid_regs_pkg::word_t       bank_offset,
    output vid_regs_pkg::word_t       bank_mask
);

    vid_regs_pkg::cfg_byte_t sr [`VR_CFG_BYTES];

    // last byte in lands at index 0
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            sr[0] <= cfg_data;
            for (int i = 1; i < `VR_CFG_BYTES; i++)
                sr[i] <= sr[i-1];
        end
    end

    // byte addresses halved to word addresses
    assign addr_id       = sr[0][5:1];
    assign addr_mult1    = sr[2][5:1];
    assign addr_mult2    = sr[3][5:1];
    assign addr_rslt0    = sr[4][5:1];
    assign addr_rslt1    = sr[5][5:1];
    assign addr_layer    = sr[6][5:1];
    assign addr_prio0    = sr[7][5:1];
    assign addr_prio1    = sr[8][5:1];
    assign addr_prio2    = sr[9][5:1];
    assign addr_prio3    = sr[10][5:1];
    assign addr_pal_page = sr[11][5:1];
    assign board_id      = sr[1];

    assign layer_mask0 = sr[12];
    assign layer_mask1 = sr[13];
    assign layer_mask2 = sr[14];
    assign layer_mask3 = sr[15];
    // layer 4 shares the layer 3 mask
    assign layer_mask4 = sr[15];

    assign game        = sr[16][5:0];
    assign bank_offset = {sr[18], sr[17]};
    assign bank_mask   = {sr[20], sr[19]};

endmodule

// ==== verilog/board_reg_bank.sv ====
// configurable-address register bank
// multiplier, board ID readback, layer control, priorities and palette
// page enable at addresses taken from the board configuration

`timescale 1ns/1ps
`include "vid_regs_defines.svh"

module board_reg_bank (
    input  logic                    clk,
    input  logic                    reg_rst,
    vid_bus_if.board_bank           bus,
    input  vid_regs_pkg::reg_addr_t addr_id,
    input  vid_regs_pkg::reg_addr_t addr_mult1,
    input  vid_regs_pkg::reg_addr_t addr_mult2,
    input  vid_regs_pkg::reg_addr_t addr_rslt0,
    input  vid_regs_pkg::reg_addr_t addr_rslt1,
    input  vid_regs_pkg::reg_addr_t addr_layer,
    input  vid_regs_pkg::reg_addr_t addr_prio0,
    input  vid_regs_pkg::reg_addr_t addr_prio1,
    input  vid_regs_pkg::reg_addr_t addr_prio2,
    input  vid_regs_pkg::reg_addr_t addr_prio3,
    input  vid_regs_pkg::reg_addr_t addr_pal_page,
    input  vid_regs_pkg::cfg_byte_t board_id,
    output vid_regs_pkg::word_t     layer_ctrl,
    output vid_regs_pkg::word_t     prio0,
    output vid_regs_pkg::word_t     prio1,
    output vid_regs_pkg::word_t     prio2,
    output vid_regs_pkg::word_t     prio3,
    output logic [5:0]              pal_page_en
);

    vid_regs_pkg::word_t mult1;
    vid_regs_pkg::word_t mult2;
    vid_regs_pkg::word_t rslt0;
    vid_regs_pkg::word_t rslt1;
    vid_regs_pkg::word_t rd_mux;
    logic [10:0] hit;
    logic        grp_a;
    logic        grp_b;
    logic        wr_full;

    assign hit = {
        bus.addr == addr_pal_page,
        bus.addr == addr_prio3,
        bus.addr == addr_prio2,
        bus.addr == addr_prio1,
        bus.addr == addr_prio0,
        bus.addr == addr_layer,
        bus.addr == addr_rslt1,
        bus.addr == addr_rslt0,
        bus.addr == addr_mult2,
        bus.addr == addr_mult1,
        bus.addr == addr_id
    };

    // two readback groups, as on the chip
    assign grp_a = |hit[5:0];
    assign grp_b = |hit[10:6];

    // only full word writes land here
    assign wr_full = bus.sel_board && bus.write && (bus.lanes == 2'b00);

    always_comb begin
        rd_mux = '1;
        if (!(&bus.addr)) begin
            if (hit[0])
                rd_mux = {4'd0, board_id[7:4], 4'd0, board_id[3:0]};
            else if (hit[1])
                rd_mux = mult1;
            else if (hit[2])
                rd_mux = mult2;
            else if (hit[3])
                rd_mux = rslt0;
            else if (hit[4])
                rd_mux = rslt1;
            else if (hit[5])
                rd_mux = layer_ctrl;
            else if (hit[6])
                rd_mux = prio0;
            else if (hit[7])
                rd_mux = prio1;
            else if (hit[8])
                rd_mux = prio2;
            else if (hit[9])
                rd_mux = prio3;
            else if (hit[10])
                rd_mux = {10'd0, pal_page_en};
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1       <= '0;
            mult2       <= '0;
            rslt0       <= '0;
            rslt1       <= '0;
            layer_ctrl  <= '0;
            prio0       <= `VR_PRIO_RESET;
            prio1       <= `VR_PRIO_RESET;
            prio2       <= `VR_PRIO_RESET;
            prio3       <= `VR_PRIO_RESET;
            pal_page_en <= `VR_PAL_PAGE_RESET;
            bus.rdata   <= '1;
        end else begin
            // product follows the operands one cycle later
            {rslt1, rslt0} <= mult1 * mult2;
            if (bus.sel_board && !bus.write)
                bus.rdata <= rd_mux;
            if (wr_full) begin
                if (hit[1])
                    mult1 <= bus.wdata;
                if (hit[2])
                    mult2 <= bus.wdata;
                if (hit[5])
                    layer_ctrl <= bus.wdata;
                if (hit[6])
                    prio0 <= bus.wdata;
                if (hit[7])
                    prio1 <= bus.wdata;
                if (hit[8])
                    prio2 <= bus.wdata;
                if (hit[9])
                    prio3 <= bus.wdata;
                if (hit[10])
                    pal_page_en <= bus.wdata[5:0];
            end
        end
    end

    a_one_group: assert property (@(posedge clk) disable iff (reg_rst)
        bus.sel_board && !bus.write && !(&bus.addr) |-> !(grp_a && grp_b));

endmodule

// ==== verilog/vid_regs_top.sv ====
// video register front end, top level
// host bridge, fixed bank, configurable bank and board configuration

`timescale 1ns/1ps

module vid_regs_top (
    input  logic                    clk,
    input  logic                    reg_rst,
    input  logic                    vid_rst_n,
    // host request
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_write,
    input  logic                    req_bank,
    input  vid_regs_pkg::reg_addr_t req_addr,
    input  logic [1:0]              req_be,
    input  vid_regs_pkg::word_t     req_wdata,
    // host response
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output vid_regs_pkg::word_t     rsp_rdata,
    // configuration stream
    input  logic                    cfg_we,
    input  vid_regs_pkg::cfg_byte_t cfg_data,
    // fixed bank
    output vid_regs_pkg::word_t     ppu_ctrl,
    output vid_regs_pkg::word_t     hpos1,
    output vid_regs_pkg::word_t     hpos2,
    output vid_regs_pkg::word_t     hpos3,
    output vid_regs_pkg::word_t     vpos1,
    output vid_regs_pkg::word_t     vpos2,
    output vid_regs_pkg::word_t     vpos3,
    output vid_regs_pkg::word_t     hstar1,
    output vid_regs_pkg::word_t     hstar2,
    output vid_regs_pkg::word_t     vstar1,
    output vid_regs_pkg::word_t     vstar2,
    output vid_regs_pkg::word_t     vram1_base,
    output vid_regs_pkg::word_t     vram2_base,
    output vid_regs_pkg::word_t     vram3_base,
    output vid_regs_pkg::word_t     vram_obj_base,
    output vid_regs_pkg::word_t     vram_row_base,
    output vid_regs_pkg::word_t     vram_star_base,
    output vid_regs_pkg::word_t     pal_base,
    output logic                    pal_copy,
    // board bank and configuration
    output vid_regs_pkg::word_t     layer_ctrl,
    output vid_regs_pkg::word_t     prio0,
    output vid_regs_pkg::word_t     prio1,
    output vid_regs_pkg::word_t     prio2,
    output vid_regs_pkg::word_t     prio3,
    output logic [5:0]              pal_page_en,
    output vid_regs_pkg::cfg_byte_t layer_mask0,
    output vid_regs_pkg::cfg_byte_t layer_mask1,
    output vid_regs_pkg::cfg_byte_t layer_mask2,
    output vid_regs_pkg::cfg_byte_t layer_mask3,
    output vid_regs_pkg::cfg_byte_t layer_mask4,
    output logic [5:0]              game,
    output vid_regs_pkg::word_t     bank_offset,
    output vid_regs_pkg::word_t     bank_mask
);

    vid_regs_pkg::reg_addr_t addr_id, addr_mult1, addr_mult2, addr_rslt0;
    vid_regs_pkg::reg_addr_t addr_rslt1, addr_layer, addr_prio0, addr_prio1;
    vid_regs_pkg::reg_addr_t addr_prio2, addr_prio3, addr_pal_page;
    vid_regs_pkg::cfg_byte_t board_id;
    logic bank_rst;

    // video soft reset clears the banks but keeps the configuration
    assign bank_rst = reg_rst | ~vid_rst_n;

    vid_bus_if bus ();

    host_bus_bridge u_bridge (
        .clk, .reg_rst, .req_valid, .req_ready, .req_write, .req_bank,
        .req_addr, .req_be, .req_wdata, .rsp_valid, .rsp_ready, .rsp_rdata,
        .bus (bus.bridge)
    );

    fixed_reg_bank u_fixed (
        .clk, .reg_rst (bank_rst), .bus (bus.fixed_bank),
        .ppu_ctrl, .hpos1, .hpos2, .hpos3, .vpos1, .vpos2, .vpos3,
        .hstar1, .hstar2, .vstar1, .vstar2,
        .vram1_base, .vram2_base, .vram3_base, .vram_obj_base,
        .vram_row_base, .vram_star_base, .pal_base, .pal_copy
    );

    board_config u_cfg (
        .clk, .cfg_we, .cfg_data,
        .addr_id, .addr_mult1, .addr_mult2, .addr_rslt0, .addr_rslt1,
        .addr_layer, .addr_prio0, .addr_prio1, .addr_prio2, .addr_prio3,
        .addr_pal_page, .board_id,
        .layer_mask0, .layer_mask1, .layer_mask2, .layer_mask3, .layer_mask4,
        .game, .bank_offset, .bank_mask
    );

    board_reg_bank u_board (
        .clk, .reg_rst (bank_rst), .bus (bus.board_bank),
        .addr_id, .addr_mult1, .addr_mult2, .addr_rslt0, .addr_rslt1,
        .addr_layer, .addr_prio0, .addr_prio1, .addr_prio2, .addr_prio3,
        .addr_pal_page, .board_id,
        .layer_ctrl, .prio0, .prio1, .prio2, .prio3, .pal_page_en
    );

endmodule

// ==== testbench/tb_vid_regs.sv ====
// testbench for the video register front end
// random host traffic under response back-pressure
// checked against a register model built from the bank rules

`timescale 1ns/1ps

module tb_vid_regs;

    logic                    clk;
    logic                    reg_rst;
    logic                    vid_rst_n;
    logic                    req_valid;
    logic                    req_ready;
    logic                    req_write;
    logic                    req_bank;
    vid_regs_pkg::reg_addr_t req_addr;
    logic [1:0]              req_be;
    vid_regs_pkg::word_t     req_wdata;
    logic                    rsp_valid;
    logic                    rsp_ready;
    vid_regs_pkg::word_t     rsp_rdata;
    logic                    cfg_we;
    logic [7:0]              cfg_data;
    // fixed bank outputs in chip register order
    wire [17:0][15:0]        fx_out;
    wire [3:0][15:0]         prio;
    wire [4:0][7:0]          mask;
    logic                    pal_copy;
    vid_regs_pkg::word_t     layer_ctrl;
    logic [5:0]              pal_page_en;
    logic [5:0]              game;
    vid_regs_pkg::word_t     bank_offset;
    vid_regs_pkg::word_t     bank_mask;

    int    seed;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    string cur_test;
    int    access_count;
    int    req_count;
    int    rsp_count;
    int    pal_writes;
    int    pulses;
    int    long_pulses;
    logic  copy_last;

    vid_regs_pkg::word_t     fx_model [18];
    // id, mult1, mult2, rslt0, rslt1, layer, prio0..3, palette page
    vid_regs_pkg::word_t     brd_model [11];
    vid_regs_pkg::reg_addr_t board_map [11];
    logic [7:0]              cfg [21];

    vid_regs_top u_dut (
        .clk, .reg_rst, .vid_rst_n,
        .req_valid, .req_ready, .req_write, .req_bank, .req_addr, .req_be, .req_wdata,
        .rsp_valid, .rsp_ready, .rsp_rdata, .cfg_we, .cfg_data,
        .vram_obj_base (fx_out[0]), .vram1_base (fx_out[1]), .vram2_base (fx_out[2]),
        .vram3_base (fx_out[3]), .vram_row_base (fx_out[4]), .pal_base (fx_out[5]),
        .hpos1 (fx_out[6]), .vpos1 (fx_out[7]), .hpos2 (fx_out[8]), .vpos2 (fx_out[9]),
        .hpos3 (fx_out[10]), .vpos3 (fx_out[11]), .hstar1 (fx_out[12]),
        .vstar1 (fx_out[13]), .hstar2 (fx_out[14]), .vstar2 (fx_out[15]),
        .vram_star_base (fx_out[16]), .ppu_ctrl (fx_out[17]), .pal_copy,
        .layer_ctrl, .prio0 (prio[0]), .prio1 (prio[1]), .prio2 (prio[2]),
        .prio3 (prio[3]), .pal_page_en,
        .layer_mask0 (mask[0]), .layer_mask1 (mask[1]), .layer_mask2 (mask[2]),
        .layer_mask3 (mask[3]), .layer_mask4 (mask[4]),
        .game, .bank_offset, .bank_mask
    );

    always #20 clk = ~clk;

    // pal_copy pulses counted on the falling edge
    always @(negedge clk) begin
        if (!reg_rst) begin
            if (pal_copy)
                pulses++;
            if (pal_copy && copy_last)
                long_pulses++;
        end
        copy_last = pal_copy;
    end

    // request and response transfers seen on the host ports
    always @(posedge clk) begin
        if (!reg_rst) begin
            if (req_valid && req_ready)
                req_count++;
            if (rsp_valid && rsp_ready)
                rsp_count++;
        end
    end

    task automatic report_mismatch(input string what, input vid_regs_pkg::word_t exp,
                                   input vid_regs_pkg::word_t act);
        $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errors_at_start)
            tests_failed++;
        $display("test %s finished, %0d errors", cur_test, errors - errors_at_start);
    endtask

    // expected board bank read data
    function automatic vid_regs_pkg::word_t expect_board_read(
        input vid_regs_pkg::reg_addr_t a
    );
        logic [31:0] prod;
        prod = {16'd0, brd_model[1]} * {16'd0, brd_model[2]};
        if (a == 5'h1f)
            return 16'hffff;
        for (int k = 0; k < 11; k++) begin
            if (a == board_map[k]) begin
                if (k == 0)
                    return {4'h0, cfg[1][7:4], 4'h0, cfg[1][3:0]};
                else if (k == 3)
                    return prod[15:0];
                else if (k == 4)
                    return prod[31:16];
                else
                    return brd_model[k];
            end
        end
        return 16'hffff;
    endfunction

    task automatic check_outputs();
        for (int i = 0; i < 18; i++)
            if (fx_out[i] !== fx_model[i])
                report_mismatch($sformatf("fixed reg %0d", i), fx_model[i], fx_out[i]);
        if (layer_ctrl !== brd_model[5])
            report_mismatch("layer_ctrl", brd_model[5], layer_ctrl);
        for (int i = 0; i < 4; i++)
            if (prio[i] !== brd_model[6+i])
                report_mismatch($sformatf("prio%0d", i), brd_model[6+i], prio[i]);
        if ({10'd0, pal_page_en} !== brd_model[10])
            report_mismatch("pal_page_en", brd_model[10], {10'd0, pal_page_en});
    endtask

    // one request and its response under random back-pressure
    task automatic host_access(input logic wr, input logic bk, input vid_regs_pkg::reg_addr_t a,
                               input logic [1:0] be, input vid_regs_pkg::word_t wd,
                               output vid_regs_pkg::word_t rd);
        int                  waited;
        logic                seen;
        logic                take;
        vid_regs_pkg::word_t held;
        waited = 0;
        seen = 1'b0;
        take = 1'b0;
        held = '0;
        access_count++;
        req_valid = 1'b1;
        req_write = wr;
        req_bank = bk;
        req_addr = a;
        req_be = be;
        req_wdata = wd;
        while (!req_ready) begin
            waited++;
            if (waited > 10) begin
                $display("timeout: request in %s was never accepted", cur_test);
                $display("CHECKS FAILED");
                $finish;
            end
            @(negedge clk);
        end
        @(negedge clk);
        waited = 0;
        while (!take) begin
            // a stray request must not be taken while this one is open
            req_valid = $random(seed);
            req_wdata = $random(seed);
            if (req_ready)
                report_error("request port ready while a response was pending");
            if (rsp_valid) begin
                if (seen && rsp_rdata !== held)
                    report_mismatch("held rsp_rdata", held, rsp_rdata);
                seen = 1'b1;
                held = rsp_rdata;
                take = (($random(seed) & 3) != 0);
                rsp_ready = take;
            end else begin
                if (seen)
                    report_error("rsp_valid dropped before the response was taken");
                rsp_ready = $random(seed);
            end
            if (take)
                req_valid = 1'b0;
            waited++;
            if (waited > 200) begin
                $display("timeout: no response in %s", cur_test);
                $display("CHECKS FAILED");
                $finish;
            end
            @(negedge clk);
        end
        rsp_ready = 1'b0;
        if (rsp_valid)
            report_error("response still valid after it was taken");
        rd = held;
    endtask

    // access, model update and output compare
    task automatic checked_access(input logic bk, input logic wr, input vid_regs_pkg::reg_addr_t a,
                                  input logic [1:0] be, input vid_regs_pkg::word_t wd);
        vid_regs_pkg::word_t rd;
        vid_regs_pkg::word_t exp;
        exp = 16'hffff;
        if (bk && !wr)
            exp = expect_board_read(a);
        host_access(wr, bk, a, be, wd, rd);
        if (!wr && rd !== exp)
            report_mismatch($sformatf("read bank %0d addr %h", bk, a), exp, rd);
        if (!bk && wr && a < 18) begin
            if (be[1])
                fx_model[a][15:8] = wd[15:8];
            if (be[0])
                fx_model[a][7:0] = wd[7:0];
        end
        if (!bk && wr && a == 5)
            pal_writes++;
        // board writes only land with both lanes on at a writable address
        if (bk && wr && be == 2'b11) begin
            for (int k = 1; k < 11; k++)
                if (a == board_map[k] && k != 3 && k != 4)
                    brd_model[k] = (k == 10) ? {10'd0, wd[5:0]} : wd;
        end
        check_outputs();
    endtask

    initial begin
        int                      idx;
        logic                    wr;
        logic [1:0]              be;
        vid_regs_pkg::reg_addr_t a;
        vid_regs_pkg::word_t     op1;
        vid_regs_pkg::word_t     op2;
        seed = 63121;
        clk = 1'b0;
        reg_rst = 1'b1;
        vid_rst_n = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_bank = 1'b0;
        req_addr = '0;
        req_be = 2'b00;
        req_wdata = '0;
        rsp_ready = 1'b0;
        cfg_we = 1'b0;
        cfg_data = 8'h00;
        copy_last = 1'b0;
        board_map = '{5'd2, 5'd4, 5'd5, 5'd6, 5'd7, 5'd9, 5'd12, 5'd13, 5'd14, 5'd15, 5'd17};
        for (int i = 0; i < 18; i++)
            fx_model[i] = '0;
        for (int k = 0; k < 11; k++)
            brd_model[k] = (k >= 6 && k <= 9) ? 16'hffff : '0;
        brd_model[10] = 16'h003f;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reg_rst = 1'b0;
        @(negedge clk);

        start_test("reset");
        check_outputs();
        if (pal_copy !== 1'b0)
            report_error("pal_copy high after reset");
        if (req_ready !== 1'b1 || rsp_valid !== 1'b0)
            report_error("handshake not idle after reset");
        end_test();

        start_test("config");
        // byte addresses are the word addresses doubled
        cfg[0] = {2'b00, board_map[0], 1'b0};
        cfg[1] = 8'ha5;
        for (int k = 1; k < 11; k++)
            cfg[k+1] = {2'b00, board_map[k], 1'b0};
        for (int i = 12; i < 21; i++)
            cfg[i] = $random(seed);
        for (int i = 20; i >= 0; i--) begin
            cfg_we = 1'b1;
            cfg_data = cfg[i];
            @(negedge clk);
        end
        cfg_we = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 5; i++)
            if (mask[i] !== cfg[12 + ((i == 4) ? 3 : i)])
                report_mismatch($sformatf("layer_mask%0d", i), cfg[12 + ((i == 4) ? 3 : i)],
                                mask[i]);
        if (game !== cfg[16][5:0])
            report_mismatch("game", cfg[16][5:0], game);
        if (bank_offset !== {cfg[18], cfg[17]})
            report_mismatch("bank_offset", {cfg[18], cfg[17]}, bank_offset);
        if (bank_mask !== {cfg[20], cfg[19]})
            report_mismatch("bank_mask", {cfg[20], cfg[19]}, bank_mask);
        // reset values seen through the host port
        for (int i = 0; i < 32; i++)
            checked_access(1'b1, 1'b0, i, 2'b11, '0);
        end_test();

        start_test("fixed bank");
        repeat (60) begin
            a = $random(seed);
            if (($random(seed) & 7) == 0)
                a = 5'd5;
            wr = (($random(seed) & 3) != 0);
            checked_access(1'b0, wr, a, $random(seed), $random(seed));
        end
        end_test();

        start_test("board bank");
        repeat (60) begin
            idx = $unsigned($random(seed)) % 11;
            a = (($random(seed) & 1) != 0) ? board_map[idx] : 5'($random(seed));
            be = (($random(seed) & 1) != 0) ? 2'b11 : 2'($random(seed));
            checked_access(1'b1, $random(seed), a, be, $random(seed));
        end
        checked_access(1'b1, 1'b0, 5'h1f, 2'b11, '0);
        checked_access(1'b1, 1'b0, board_map[0], 2'b11, '0);
        end_test();

        start_test("multiplier");
        repeat (10) begin
            op1 = $random(seed);
            op2 = $random(seed);
            checked_access(1'b1, 1'b1, board_map[1], 2'b11, op1);
            checked_access(1'b1, 1'b1, board_map[2], 2'b11, op2);
            checked_access(1'b1, 1'b0, board_map[3], 2'b11, '0);
            checked_access(1'b1, 1'b0, board_map[4], 2'b11, '0);
        end
        end_test();

        start_test("palette copy");
        repeat (5)
            checked_access(1'b0, 1'b1, 5'd5, $random(seed), $random(seed));
        // room for the last pulse to arrive
        repeat (2) @(negedge clk);
        if (pulses != pal_writes)
            report_mismatch("pal_copy pulses", pal_writes, pulses);
        if (long_pulses != 0)
            report_error("pal_copy stayed high for two cycles");
        end_test();

        start_test("handshake");
        repeat (40) begin
            idx = $unsigned($random(seed)) % 11;
            wr = $random(seed);
            if (($random(seed) & 1) != 0)
                checked_access(1'b1, wr, board_map[idx], 2'b11, $random(seed));
            else
                checked_access(1'b0, wr, $random(seed), $random(seed), $random(seed));
        end
        if (req_count != access_count || rsp_count != access_count)
            report_error($sformatf("%0d accesses gave %0d requests and %0d responses",
                                   access_count, req_count, rsp_count));
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/vid_regs_pkg.sv
verilog/vid_bus_if.sv
verilog/host_bus_bridge.sv
verilog/fixed_reg_bank.sv
verilog/board_config.sv
verilog/board_reg_bank.sv
verilog/vid_regs_top.sv
testbench/tb_vid_regs.sv

// ==== Bender.yml ====
package:
  name: vid_regs

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vid_regs_pkg.sv
      - verilog/vid_bus_if.sv
      - verilog/host_bus_bridge.sv
      - verilog/fixed_reg_bank.sv
      - verilog/board_config.sv
      - verilog/board_reg_bank.sv
      - verilog/vid_regs_top.sv
  - target: test
    files:
      - testbench/tb_vid_regs.sv
